// File: Bender.yml
package:
  name: snake_game

sources:
  - verilog/snakePkg.sv
  - verilog/moveIf.sv
  - verilog/directionDecoder.sv
  - verilog/snakeBody.sv
  - verilog/appleGenerator.sv
  - verilog/scoreTracker.sv
  - verilog/snakeGame.sv
  - target: test
    files:
      - verification/tbClock.sv
      - verification/snakeGameTb.sv

// File: tb.f
verilog/snakePkg.sv
verilog/moveIf.sv
verilog/directionDecoder.sv
verilog/snakeBody.sv
verilog/appleGenerator.sv
verilog/scoreTracker.sv
verilog/snakeGame.sv
verification/tbClock.sv
verification/snakeGameTb.sv

// File: verification/snakeGameTb.sv
// snake game testbench
// plays random games and two steered games against a reference model
// of heading, body, apple sequence and score with a reset per game
module snakeGameTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_LENGTH = 32;
  localparam int START_LENGTH = 3;
  localparam int PERIOD_NS = 20;
  localparam int RESET_CYCLES = 8;
  localparam int GAMES = 5;
  localparam int RANDOM_TICKS = 200;
  localparam int CURL_TICKS = 600;
  localparam int CURL_SCORE = 2;
  localparam int STEER_TICKS = 6000;
  localparam int EXTRA_TICKS = 3;
  localparam int TOTAL_TICKS = (GAMES - 2) * RANDOM_TICKS + CURL_TICKS + STEER_TICKS +
                               GAMES * EXTRA_TICKS;
  localparam int WATCHDOG_NS = TOTAL_TICKS * 12 * PERIOD_NS + GAMES * RESET_CYCLES * PERIOD_NS;
  localparam logic [31:0] RAND_SEED = 32'hdf9b;
  localparam logic [31:0] RAND_TAPS = 32'h80200003;
  localparam logic [7:0] APPLE_SEED = 8'hA5;
  localparam logic [7:0] APPLE_TAPS = 8'hB8;

  logic hwclk;
  logic arstN;
  logic resetReq;
  logic [3:0] buttons;
  logic stepPulse;
  snakePkg::coord_t headX;
  snakePkg::coord_t headY;
  snakePkg::coord_t appleX;
  snakePkg::coord_t appleY;
  snakePkg::bcd_t ones;
  snakePkg::bcd_t tens;
  snakePkg::bcd_t hundreds;
  snakePkg::score_t score;
  logic gameOver;

  // reference model state
  snakePkg::heading_t mHeading;
  snakePkg::coord_t mBodyX [MAX_LENGTH];
  snakePkg::coord_t mBodyY [MAX_LENGTH];
  int mLength;
  logic [7:0] mLfsr;
  snakePkg::coord_t mAppleX;
  snakePkg::coord_t mAppleY;
  int mScore;
  logic mGameOver;
  logic [31:0] randState;

  tbClock clockGen (
    .hwclk_o   (hwclk),
    .arstN_o   (arstN),
    .resetReq_i(resetReq)
  );

  snakeGame #(.MAX_LENGTH(MAX_LENGTH)) i_dut (
    .hwclk          (hwclk),
    .arstN_i        (arstN),
    .buttons_i      (buttons),
    .stepPulse_i    (stepPulse),
    .headX_o        (headX),
    .headY_o        (headY),
    .appleX_o       (appleX),
    .appleY_o       (appleY),
    .scoreOnes_o    (ones),
    .scoreTens_o    (tens),
    .scoreHundreds_o(hundreds),
    .score_o        (score),
    .gameOver_o     (gameOver)
  );

  // galois lfsr stepped once per bit taken
  function automatic logic randBit();
    logic b;
    b = randState[0];
    randState = {1'b0, randState[31:1]};
    if (b) begin
      randState = randState ^ RAND_TAPS;
    end
    return b;
  endfunction

  function automatic snakePkg::heading_t randHeading();
    logic [1:0] v;
    v[0] = randBit();
    v[1] = randBit();
    return snakePkg::heading_t'(v);
  endfunction

  function automatic snakePkg::heading_t opposite(snakePkg::heading_t h);
    case (h)
      snakePkg::UP:   return snakePkg::DOWN;
      snakePkg::DOWN: return snakePkg::UP;
      snakePkg::LEFT: return snakePkg::RIGHT;
      default:        return snakePkg::LEFT;
    endcase
  endfunction

  // apple sequence shifts right and folds in the taps on a 1 out
  function automatic logic [7:0] appleSeqStep(logic [7:0] s);
    logic [7:0] t;
    t = {1'b0, s[7:1]};
    if (s[0]) begin
      t = t ^ APPLE_TAPS;
    end
    return t;
  endfunction

  function automatic snakePkg::coord_t nibbleCell(logic [3:0] n);
    return snakePkg::coord_t'(1 + int'(n) % 14);
  endfunction

  // closed tour of the 14x14 interior with column 1 as the way back up
  function automatic snakePkg::heading_t tourHeading(snakePkg::coord_t x, snakePkg::coord_t y);
    if (x == 4'd1) begin
      return (y == 4'd1) ? snakePkg::RIGHT : snakePkg::UP;
    end
    if (y[0]) begin
      return (x == 4'd14) ? snakePkg::DOWN : snakePkg::RIGHT;
    end
    if (y == 4'd14 || x != 4'd2) begin
      return snakePkg::LEFT;
    end
    return snakePkg::DOWN;
  endfunction

  function automatic snakePkg::heading_t steerHeading();
    snakePkg::heading_t h;
    h = tourHeading(mBodyX[0], mBodyY[0]);
    // joining the tour from the start row would mean turning back
    if (h == opposite(mHeading)) begin
      if (mHeading == snakePkg::LEFT || mHeading == snakePkg::RIGHT) begin
        h = (mBodyY[0] < 4'd14) ? snakePkg::DOWN : snakePkg::UP;
      end else begin
        h = (mBodyX[0] < 4'd14) ? snakePkg::RIGHT : snakePkg::LEFT;
      end
    end
    return h;
  endfunction

  task automatic reportMismatch(string what, logic [7:0] exp, logic [7:0] act);
    $display("[ERROR] %0t ns: %s expected %0d, actual %0d", $time, what, exp, act);
    $display("Test failures found");
    $fatal(1, "mismatch on %s", what);
  endtask

  task automatic checkCoord(string what, snakePkg::coord_t exp, snakePkg::coord_t act);
    if (act !== exp) begin
      reportMismatch(what, 8'(exp), 8'(act));
    end
  endtask

  task automatic checkBcd(string what, snakePkg::bcd_t exp, snakePkg::bcd_t act);
    if (act !== exp) begin
      reportMismatch(what, 8'(exp), 8'(act));
    end
  endtask

  task automatic checkScore(string what, snakePkg::score_t exp, snakePkg::score_t act);
    if (act !== exp) begin
      reportMismatch(what, exp, act);
    end
  endtask

  task automatic checkFlag(string what, logic exp, logic act);
    if (act !== exp) begin
      reportMismatch(what, 8'(exp), 8'(act));
    end
  endtask

  task automatic resetModel();
    mHeading = snakePkg::RIGHT;
    // body trails left of the start head with spare slots on the tail
    for (int i = 0; i < MAX_LENGTH; i++) begin
      mBodyX[i] = (i < START_LENGTH) ? snakePkg::coord_t'(8 - i) : 4'd6;
      mBodyY[i] = 4'd8;
    end
    mLength = START_LENGTH;
    mLfsr = APPLE_SEED;
    mAppleX = nibbleCell(APPLE_SEED[7:4]);
    mAppleY = nibbleCell(APPLE_SEED[3:0]);
    mScore = 0;
    mGameOver = 1'b0;
  endtask

  task automatic modelPress(snakePkg::heading_t b);
    // turning back onto the neck is ignored
    if (b != opposite(mHeading)) begin
      mHeading = b;
    end
  endtask

  task automatic modelStep();
    snakePkg::coord_t nx;
    snakePkg::coord_t ny;
    logic crash;
    logic eat;
    nx = mBodyX[0];
    ny = mBodyY[0];
    if (mGameOver) begin
      return;
    end
    case (mHeading)
      snakePkg::UP:   ny = ny - 4'd1;
      snakePkg::DOWN: ny = ny + 4'd1;
      snakePkg::LEFT: nx = nx - 4'd1;
      default:        nx = nx + 4'd1;
    endcase
    crash = (nx == 4'd0) || (nx == 4'd15) || (ny == 4'd0) || (ny == 4'd15);
    // the tail cell is vacated by this move
    for (int i = 0; i < mLength - 1; i++) begin
      if (mBodyX[i] == nx && mBodyY[i] == ny) begin
        crash = 1'b1;
      end
    end
    for (int i = MAX_LENGTH - 1; i > 0; i--) begin
      mBodyX[i] = mBodyX[i-1];
      mBodyY[i] = mBodyY[i-1];
    end
    mBodyX[0] = nx;
    mBodyY[0] = ny;
    mLfsr = appleSeqStep(mLfsr);
    eat = !crash && (nx == mAppleX) && (ny == mAppleY);
    if (eat) begin
      mLength++;
      mScore++;
      mAppleX = nibbleCell(mLfsr[7:4]);
      mAppleY = nibbleCell(mLfsr[3:0]);
    end
    if (crash || (eat && START_LENGTH + mScore >= MAX_LENGTH)) begin
      mGameOver = 1'b1;
    end
  endtask

  task automatic compareAll();
    checkCoord("head x", mBodyX[0], headX);
    checkCoord("head y", mBodyY[0], headY);
    checkCoord("apple x", mAppleX, appleX);
    checkCoord("apple y", mAppleY, appleY);
    checkScore("score", snakePkg::score_t'(mScore), score);
    checkBcd("score ones", snakePkg::bcd_t'(mScore % 10), ones);
    checkBcd("score tens", snakePkg::bcd_t'((mScore / 10) % 10), tens);
    checkBcd("score hundreds", snakePkg::bcd_t'(mScore / 100), hundreds);
    checkFlag("game over", mGameOver, gameOver);
  endtask

  // press and release a button, tick and compare once the move has settled
  task automatic playTick(snakePkg::heading_t b);
    @(posedge hwclk);
    #2;
    buttons = 4'b0001 << b;
    repeat (5) @(posedge hwclk);
    #2;
    buttons = '0;
    modelPress(b);
    @(posedge hwclk);
    #2;
    stepPulse = 1'b1;
    @(posedge hwclk);
    #2;
    stepPulse = 1'b0;
    modelStep();
    repeat (3) @(posedge hwclk);
    #2;
    compareAll();
  endtask

  task automatic startGame();
    @(posedge hwclk);
    #2;
    resetReq = 1'b1;
    @(posedge arstN);
    resetReq = 1'b0;
    resetModel();
    repeat (2) @(posedge hwclk);
    #2;
    compareAll();
  endtask

  task automatic playRandomGame();
    int n;
    n = 0;
    while (!mGameOver && n < RANDOM_TICKS) begin
      playTick(randHeading());
      n++;
    end
  endtask

  // grow on the tour until the body is long enough to bite itself
  task automatic playCurlGame();
    int n;
    n = 0;
    while (!mGameOver && n < CURL_TICKS &&
           !(mScore >= CURL_SCORE && mHeading == snakePkg::RIGHT)) begin
      playTick(steerHeading());
      n++;
    end
    // three clockwise turns close a square onto the body inside the wall
    playTick(snakePkg::DOWN);
    playTick(snakePkg::LEFT);
    playTick(snakePkg::UP);
    checkFlag("game over on body hit", 1'b1, gameOver);
  endtask

  task automatic playSteeredGame();
    int n;
    n = 0;
    while (!mGameOver && n < STEER_TICKS) begin
      playTick(steerHeading());
      n++;
    end
    // full body length ends the game without a crash
    checkScore("score at full length", snakePkg::score_t'(MAX_LENGTH - START_LENGTH), score);
    checkFlag("game over at full length", 1'b1, gameOver);
  endtask

  initial begin
    randState = RAND_SEED;
    buttons = '0;
    stepPulse = 1'b0;
    resetReq = 1'b0;
    for (int g = 0; g < GAMES; g++) begin
      startGame();
      if (g == GAMES - 1) begin
        playSteeredGame();
      end else if (g == GAMES - 2) begin
        playCurlGame();
      end else begin
        playRandomGame();
      end
      // ticks after the end leave the game frozen
      for (int i = 0; i < EXTRA_TICKS; i++) begin
        playTick(randHeading());
      end
    end
    $display("All tests passed!");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, the games did not finish in time");
    $display("Test failures found");
    $fatal(1, "timeout");
  end

endmodule

// File: verification/tbClock.sv
// testbench clock and reset
// free running 20 ns clock; every reset request holds the
// active low reset for 8 cycles and releases it after a rising edge
module tbClock (
  output logic hwclk_o,
  output logic arstN_o,
  input  logic resetReq_i
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int PERIOD_NS = 20;
  localparam int RESET_CYCLES = 8;

  initial begin
    hwclk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2);
      hwclk_o = ~hwclk_o;
    end
  end

  // low from time 0 until the first request completes
  initial begin
    arstN_o = 1'b0;
    forever begin
      @(posedge resetReq_i);
      arstN_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge hwclk_o);
      #2;
      arstN_o = 1'b1;
    end
  end

endmodule

// File: verilog/appleGenerator.sv
// apple generator
// steps an 8-bit galois lfsr on every move and places a new apple
// when the head eats the current one; apples stay inside the wall
module appleGenerator (
  input  logic             hwclk,
  input  logic             arstN_i,
  moveIf.apple             move,
  output snakePkg::coord_t appleX_o,
  output snakePkg::coord_t appleY_o
);

  snakePkg::lfsr_t lfsrQ;
  snakePkg::lfsr_t lfsrNext;

  // one galois step, shifts right and folds in the taps
  function automatic snakePkg::lfsr_t lfsrStep(snakePkg::lfsr_t s);
    if (s[0]) begin
      return (s >> 1) ^ snakePkg::LFSR_TAPS;
    end
    return s >> 1;
  endfunction

  // nibble to a cell in 1..14
  function automatic snakePkg::coord_t toCell(logic [3:0] n);
    return snakePkg::coord_t'(4'd1 + (n % 4'd14));
  endfunction

  assign lfsrNext = lfsrStep(lfsrQ);

  // no eat on a crashing move
  assign move.eat = move.moveValid && !move.crash &&
                    (move.headX == appleX_o) && (move.headY == appleY_o);

  always_ff @(posedge hwclk or negedge arstN_i) begin
    if (!arstN_i) begin
      lfsrQ    <= snakePkg::LFSR_SEED;
      appleX_o <= toCell(snakePkg::LFSR_SEED[7:4]);
      appleY_o <= toCell(snakePkg::LFSR_SEED[3:0]);
    end else if (move.moveValid) begin
      lfsrQ <= lfsrNext;
      // new apple from the stepped value
      if (move.eat) begin
        appleX_o <= toCell(lfsrNext[7:4]);
        appleY_o <= toCell(lfsrNext[3:0]);
      end
    end
  end

endmodule

// File: verilog/directionDecoder.sv
// direction decoder
// synchronizes the four direction buttons, detects rising edges and
// keeps the current heading; a press that reverses the snake is dropped
// buttons_i bit order follows heading_t: 0 up, 1 down, 2 left, 3 right
module directionDecoder (
  input  logic                hwclk,
  input  logic                arstN_i,
  input  logic          [3:0] buttons_i,
  output snakePkg::heading_t  heading_o
);

  logic [3:0] syncQ1;
  logic [3:0] syncQ2;
  logic [3:0] prevQ;
  logic [3:0] rise;
  logic anyRise;
  logic reverse;
  snakePkg::heading_t wanted;

  // opposite headings differ only in bit 0
  function automatic logic isReverse(snakePkg::heading_t a, snakePkg::heading_t b);
    return (a ^ b) == 2'b01;
  endfunction

  // new press is a 0 -> 1 after the synchronizer
  assign rise    = syncQ2 & ~prevQ;
  assign anyRise = |rise;

  // up wins over down over left over right
  always_comb begin
    wanted = heading_o;
    if (rise[0]) begin
      wanted = snakePkg::UP;
    end else if (rise[1]) begin
      wanted = snakePkg::DOWN;
    end else if (rise[2]) begin
      wanted = snakePkg::LEFT;
    end else if (rise[3]) begin
      wanted = snakePkg::RIGHT;
    end
  end

  assign reverse = isReverse(wanted, heading_o);

  always_ff @(posedge hwclk or negedge arstN_i) begin
    if (!arstN_i) begin
      syncQ1    <= '0;
      syncQ2    <= '0;
      prevQ     <= '0;
      heading_o <= snakePkg::START_HEADING;
    end else begin
      // two flops against metastability
      syncQ1 <= buttons_i;
      syncQ2 <= syncQ1;
      prevQ  <= syncQ2;
      // turning back onto the neck is ignored
      if (anyRise && !reverse) begin
        heading_o <= wanted;
      end
    end
  end

endmodule

// File: verilog/moveIf.sv
// move interface
// carries one snake move from the body block to the apple and
// score blocks; eat comes back from the apple block in the same cycle
interface moveIf;

  // one-cycle strobe, head and crash are valid with it
  logic moveValid;
  snakePkg::coord_t headX;
  snakePkg::coord_t headY;
  // new head hit the wall or the body
  logic crash;
  // head landed on the apple, combinational
  logic eat;

  modport source (output moveValid, headX, headY, crash, input eat);

  modport apple (input moveValid, headX, headY, crash, output eat);

  modport result (input moveValid, crash, eat);

endinterface

// File: verilog/scoreTracker.sv
// score tracker
// counts eaten apples in binary and in three bcd digits, and raises a
// sticky game over on a crash or when the snake reaches full length
module scoreTracker #(
  parameter int MAX_LENGTH = 32
) (
  input  logic             hwclk,
  input  logic             arstN_i,
  moveIf.result            move,
  output snakePkg::score_t score_o,
  output snakePkg::bcd_t   scoreOnes_o,
  output snakePkg::bcd_t   scoreTens_o,
  output snakePkg::bcd_t   scoreHundreds_o,
  output logic             gameOver_o
);

  snakePkg::score_t scoreNext;
  snakePkg::bcd_t onesNext;
  snakePkg::bcd_t tensNext;
  snakePkg::bcd_t hundredsNext;
  logic fullLength;

  // bcd increment, each digit wraps after 9
  always_comb begin
    onesNext     = scoreOnes_o + snakePkg::bcd_t'(1);
    tensNext     = scoreTens_o;
    hundredsNext = scoreHundreds_o;
    if (scoreOnes_o == 4'd9) begin
      onesNext = '0;
      tensNext = scoreTens_o + snakePkg::bcd_t'(1);
      if (scoreTens_o == 4'd9) begin
        tensNext     = '0;
        hundredsNext = scoreHundreds_o + snakePkg::bcd_t'(1);
      end
    end
  end

  assign scoreNext = score_o + snakePkg::score_t'(1);

  // body length after this eat
  assign fullLength = (snakePkg::START_LENGTH + int'(scoreNext)) >= MAX_LENGTH;

  always_ff @(posedge hwclk or negedge arstN_i) begin
    if (!arstN_i) begin
      score_o         <= '0;
      scoreOnes_o     <= '0;
      scoreTens_o     <= '0;
      scoreHundreds_o <= '0;
      gameOver_o      <= 1'b0;
    end else if (move.moveValid) begin
      if (move.eat) begin
        score_o         <= scoreNext;
        scoreOnes_o     <= onesNext;
        scoreTens_o     <= tensNext;
        scoreHundreds_o <= hundredsNext;
      end
      // sticky until the next reset
      if (move.crash || (move.eat && fullLength)) begin
        gameOver_o <= 1'b1;
      end
    end
  end

  // crash from the body block must suppress eat in the apple block
  assert property (@(posedge hwclk) disable iff (!arstN_i)
    !(move.eat && move.crash));

endmodule

// File: verilog/snakeBody.sv
// snake body
// holds the body as a list of cells with the head in slot 0; a game
// tick moves the head one cell along the heading and shifts the body,
// flags wall and self collisions and grows the snake after an eat
module snakeBody #(
  parameter int MAX_LENGTH = 32
) (
  input  logic               hwclk,
  input  logic               arstN_i,
  input  snakePkg::heading_t heading_i,
  input  logic               stepPulse_i,
  input  logic               gameOver_i,
  moveIf.source              move
);

  snakePkg::coord_t bodyX [MAX_LENGTH];
  snakePkg::coord_t bodyY [MAX_LENGTH];
  snakePkg::length_t length;
  snakePkg::coord_t nextX;
  snakePkg::coord_t nextY;
  logic stepQ;
  logic moveValidQ;
  logic crashQ;
  logic wallHit;
  logic bodyHit;

  // head candidate, up is toward row 0
  always_comb begin
    nextX = bodyX[0];
    nextY = bodyY[0];
    case (heading_i)
      snakePkg::UP:    nextY = bodyY[0] - 4'd1;
      snakePkg::DOWN:  nextY = bodyY[0] + 4'd1;
      snakePkg::LEFT:  nextX = bodyX[0] - 4'd1;
      snakePkg::RIGHT: nextX = bodyX[0] + 4'd1;
      default:         nextX = bodyX[0];
    endcase
  end

  // outer ring of the grid is wall
  assign wallHit = (nextX == 4'd0) || (nextX == 4'd15) ||
                   (nextY == 4'd0) || (nextY == 4'd15);

  // tail cell moves away this tick, so only length-1 cells count
  always_comb begin
    bodyHit = 1'b0;
    for (int i = 0; i < MAX_LENGTH - 1; i++) begin
      if ((i + 1 < int'(length)) && (bodyX[i] == nextX) && (bodyY[i] == nextY)) begin
        bodyHit = 1'b1;
      end
    end
  end

  always_ff @(posedge hwclk or negedge arstN_i) begin
    if (!arstN_i) begin
      stepQ      <= 1'b0;
      moveValidQ <= 1'b0;
      crashQ     <= 1'b0;
      length     <= snakePkg::length_t'(snakePkg::START_LENGTH);
      // start body in a row, unused slots park on the tail
      for (int i = 0; i < MAX_LENGTH; i++) begin
        if (i < snakePkg::START_LENGTH) begin
          bodyX[i] <= snakePkg::START_X - snakePkg::coord_t'(i);
        end else begin
          bodyX[i] <= snakePkg::START_X - snakePkg::coord_t'(snakePkg::START_LENGTH - 1);
        end
        bodyY[i] <= snakePkg::START_Y;
      end
    end else begin
      // ticks are dropped once the game is over
      stepQ      <= stepPulse_i && !gameOver_i;
      moveValidQ <= stepQ;
      if (stepQ) begin
        crashQ   <= wallHit || bodyHit;
        bodyX[0] <= nextX;
        bodyY[0] <= nextY;
        // old tail stays in slot length, ready for growth
        for (int i = 1; i < MAX_LENGTH; i++) begin
          bodyX[i] <= bodyX[i-1];
          bodyY[i] <= bodyY[i-1];
        end
      end
      if (moveValidQ && move.eat) begin
        length <= length + snakePkg::length_t'(1);
      end
    end
  end

  assign move.moveValid = moveValidQ;
  assign move.crash     = crashQ;
  assign move.headX     = bodyX[0];
  assign move.headY     = bodyY[0];

  // the pipeline needs three cycles per tick
  assert property (@(posedge hwclk) disable iff (!arstN_i)
    stepPulse_i |=> !stepPulse_i [*2]);

  assert property (@(posedge hwclk) disable iff (!arstN_i)
    moveValidQ |=> !moveValidQ);

  // score block ends the game before the list can overflow
  assert property (@(posedge hwclk) disable iff (!arstN_i)
    int'(length) <= MAX_LENGTH);

endmodule

// File: verilog/snakeGame.sv
// snake game core
// top of the game logic: heading decode, body movement, apple
// placement and scoring on a 16x16 grid, advanced by a tick pulse
module snakeGame #(
  parameter int MAX_LENGTH = 32
) (
  input  logic             hwclk,
  input  logic             arstN_i,
  // up, down, left, right in bits 0..3
  input  logic       [3:0] buttons_i,
  input  logic             stepPulse_i,
  output snakePkg::coord_t headX_o,
  output snakePkg::coord_t headY_o,
  output snakePkg::coord_t appleX_o,
  output snakePkg::coord_t appleY_o,
  output snakePkg::bcd_t   scoreOnes_o,
  output snakePkg::bcd_t   scoreTens_o,
  output snakePkg::bcd_t   scoreHundreds_o,
  output snakePkg::score_t score_o,
  output logic             gameOver_o
);

  snakePkg::heading_t heading;
  logic gameOver;

  // one move per tick, body -> apple and score
  moveIf move ();

  directionDecoder decode (
    .hwclk    (hwclk),
    .arstN_i  (arstN_i),
    .buttons_i(buttons_i),
    .heading_o(heading)
  );

  snakeBody #(.MAX_LENGTH(MAX_LENGTH)) execute (
    .hwclk      (hwclk),
    .arstN_i    (arstN_i),
    .heading_i  (heading),
    .stepPulse_i(stepPulse_i),
    .gameOver_i (gameOver),
    .move       (move.source)
  );

  appleGenerator apple (
    .hwclk   (hwclk),
    .arstN_i (arstN_i),
    .move    (move.apple),
    .appleX_o(appleX_o),
    .appleY_o(appleY_o)
  );

  scoreTracker #(.MAX_LENGTH(MAX_LENGTH)) result (
    .hwclk          (hwclk),
    .arstN_i        (arstN_i),
    .move           (move.result),
    .score_o        (score_o),
    .scoreOnes_o    (scoreOnes_o),
    .scoreTens_o    (scoreTens_o),
    .scoreHundreds_o(scoreHundreds_o),
    .gameOver_o     (gameOver)
  );

  assign headX_o    = move.headX;
  assign headY_o    = move.headY;
  assign gameOver_o = gameOver;

endmodule

// File: verilog/snakePkg.sv
// snake game shared definitions
// grid coordinates, heading encoding, score and length widths,
// start position of a new game and the apple LFSR constants
package snakePkg;

  // one cell coordinate on the 16x16 grid
  typedef logic [3:0] coord_t;

  // heading encoding, also the bit order of the direction buttons
  typedef enum logic [1:0] {
    UP    = 2'd0,
    DOWN  = 2'd1,
    LEFT  = 2'd2,
    RIGHT = 2'd3
  } heading_t;

  // single bcd digit
  typedef logic [3:0] bcd_t;
  // binary apple count
  typedef logic [7:0] score_t;
  // body length in cells
  typedef logic [7:0] length_t;
  // apple pseudo-random state
  typedef logic [7:0] lfsr_t;

  // head cell of a fresh game, body trails to the left
  localparam coord_t START_X = 4'd8;
  localparam coord_t START_Y = 4'd8;
  localparam int START_LENGTH = 3;
  localparam heading_t START_HEADING = RIGHT;

  // galois lfsr, right shifting
  localparam lfsr_t LFSR_SEED = 8'hA5;
  localparam lfsr_t LFSR_TAPS = 8'hB8;

endpackage
